// ==== sim.f ====
source/joystickPkg.sv
source/spiByteIf.sv
source/spiByteEngine.sv
source/frameReader.sv
source/axisRepeater.sv
source/joystickNav.sv
verification/joystickSlaveModel.sv
verification/joystickNavTb.sv

// ==== Bender.yml ====
package:
  name: joystick_nav

sources:
  - files:
      - source/joystickPkg.sv
      - source/spiByteIf.sv
      - source/spiByteEngine.sv
      - source/frameReader.sv
      - source/axisRepeater.sv
      - source/joystickNav.sv
  - target: test
    files:
      - verification/joystickSlaveModel.sv
      - verification/joystickNavTb.sv

// ==== verification/joystickNavTb.sv ====
`timescale 1ns/1ps

module joystickNavTb import joystickPkg::*; ();

    localparam int POLL_CYCLES    = 400;
    localparam int SCLK_HALF      = 2;
    localparam int HOLD_CYCLES    = 20;
    localparam int REPEAT_CYCLES  = 6;
    // ss lead cycle plus five transfers with a hand-off cycle each
    localparam int FRAME_CYCLES   = 1 + FRAME_BYTES * (2 * SCLK_HALF * BYTE_BITS + 3);
    localparam int TIMEOUT_CYCLES = 20 * POLL_CYCLES + 1000;

    typedef struct packed {
        logic [3:0] dirs;       // Allowed pulse directions per output
        logic       click;
        logic       downClick;
        int         gap;        // Cycles up to the next pulse
    } navExpect;

    logic                 CLK, RST, miso, ss, sclk, mosi;
    logic [1:0]           leds;
    logic                 left, right, up, down, click, downClick;
    jstkFrame             frame;            // Served at the next poll
    logic [BYTE_BITS-1:0] cmdByte;
    int                   seed;
    int                   cycles = 0;
    posType               drvX, drvY, pendX, pendY, latX, latY;
    logic [1:0]           drvButtons, pendButtons, latButtons, pendLeds;
    int                   lastCycle [2];    // Last pulse or entry per axis
    int                   pulseIdx [2];
    logic                 fromOpp [2];      // Entered straight from the other side
    logic [1:0]           curDir [2];
    int                   ssLow, lastFall;
    logic                 prevSs, started;

    joystickNav #(
        .POLL_CYCLES   (POLL_CYCLES),
        .SCLK_HALF     (SCLK_HALF),
        .HOLD_CYCLES   (HOLD_CYCLES),
        .REPEAT_CYCLES (REPEAT_CYCLES)
    ) joystickNav_i (.*);

    joystickSlaveModel slave (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout, the run went past %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "Timeout");
        end
    end

    // ==================================================================
    // Reference model and checking
    // ==================================================================
    function automatic logic [1:0] axisPair(input logic [3:0] v, input int a);
        return (a == 0) ? v[3:2] : v[1:0];  // X pair above the Y pair
    endfunction

    function automatic navExpect refNav(input posType x, input posType y,
                                        input logic [1:0] buttons, input int idx,
                                        input logic opp);
        navExpect e;
        e.dirs      = {x < LOW_THRESHOLD, x > HIGH_THRESHOLD,
                       y < LOW_THRESHOLD, y > HIGH_THRESHOLD};
        e.click     = buttons[0];
        e.downClick = buttons[1];
        if (idx == 0) begin
            e.gap = opp ? 2 : 1;            // Via idle when crossing sides
        end else if (idx == 1) begin
            e.gap = HOLD_CYCLES + REPEAT_CYCLES + 2;
        end else begin
            e.gap = REPEAT_CYCLES + 1;
        end
        return e;
    endfunction

    task automatic checkEqual(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("Fail %0t: %s, expected %0d, got %0d", $time, what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "Mismatch");
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge CLK) begin : compareOutputs
        navExpect e;
        navExpect old;
        logic [1:0] newDir;
        if (RST) begin
            started = 1'b0;
        end else begin
            if (!started) begin
                // Cleared frame reads as both axes at zero
                started    = 1'b1;
                {latX, latY, latButtons} = '0;
                prevSs     = 1'b1;
                lastFall   = -1;
                e = refNav(latX, latY, latButtons, 0, 1'b0);
                for (int a = 0; a < 2; a++) begin
                    curDir[a]    = axisPair(e.dirs, a);
                    lastCycle[a] = cycles;
                    pulseIdx[a]  = 0;
                    fromOpp[a]   = 1'b0;
                end
            end
            // Pulses lag the latch by one cycle
            for (int a = 0; a < 2; a++) begin
                if (axisPair({left, right, up, down}, a) != 2'b00) begin
                    old = refNav(latX, latY, latButtons, pulseIdx[a], fromOpp[a]);
                    checkEqual(axisPair({left, right, up, down}, a), axisPair(old.dirs, a),
                               "pulse direction");
                    checkEqual(cycles - lastCycle[a], old.gap, "pulse spacing");
                    lastCycle[a] = cycles;
                    pulseIdx[a]++;
                end
            end
            if (prevSs && !ss) begin        // Frame starts
                if (lastFall >= 0) checkEqual(cycles - lastFall, POLL_CYCLES, "poll period");
                lastFall = cycles;
                ssLow    = 0;
                {pendX, pendY, pendButtons, pendLeds} = {drvX, drvY, drvButtons, leds};
            end
            if (!ss) ssLow++;
            if (ss) checkEqual({sclk, mosi}, 0, "serial lines idle between frames");
            if (!prevSs && ss) begin        // Frame latched
                checkEqual(ssLow, FRAME_CYCLES, "ss low time");
                checkEqual(cmdByte, (1 << (BYTE_BITS - 1)) | pendLeds, "command byte");
                e = refNav(pendX, pendY, pendButtons, 0, 1'b0);
                for (int a = 0; a < 2; a++) begin
                    newDir = axisPair(e.dirs, a);
                    if (newDir != curDir[a]) begin
                        if (curDir[a] != 2'b00) begin
                            old = refNav(latX, latY, latButtons, pulseIdx[a], fromOpp[a]);
                            checkEqual(int'(cycles - lastCycle[a] < old.gap), 1,
                                       "pulse overdue at release");
                        end
                        fromOpp[a]   = (curDir[a] != 2'b00) && (newDir != 2'b00);
                        curDir[a]    = newDir;
                        pulseIdx[a]  = 0;
                        lastCycle[a] = cycles;
                    end
                end
                {latX, latY, latButtons} = {pendX, pendY, pendButtons};
            end
            prevSs = ss;
            // Buttons follow the latch at once
            e = refNav(latX, latY, latButtons, 0, 1'b0);
            checkEqual(click, e.click, "click level");
            checkEqual(downClick, e.downClick, "downClick level");
        end
    end

    // ==================================================================
    // Stimulus
    // ==================================================================
    task automatic serveFrame(input posType x, input posType y, input logic [1:0] buttons,
                              input logic [1:0] ledVal);
        jstkFrame f;
        f                  = '0;
        f.fields.xLow      = x[BYTE_BITS-1:0];
        f.fields.xHigh     = x[POS_BITS-1:BYTE_BITS];
        f.fields.yLow      = y[BYTE_BITS-1:0];
        f.fields.yHigh     = y[POS_BITS-1:BYTE_BITS];
        f.fields.downClick = buttons[1];
        f.fields.click     = buttons[0];
        @(posedge CLK);
        #2;
        frame = f;
        leds  = ledVal;
        {drvX, drvY, drvButtons} = {x, y, buttons};
        @(negedge ss);                      // Slave takes it
        @(posedge ss);                      // DUT latches it
    endtask

    initial begin : stimulus
        int r;
        RST   = 1'b1;
        leds  = 2'd0;
        frame = '0;
        seed  = 14;
        {drvX, drvY, drvButtons} = '0;
        repeat (10) @(posedge CLK);
        #2 RST = 1'b0;
        serveFrame(10'd512, 10'd600, 2'b11, 2'd1);    // Center with both buttons
        serveFrame(10'd300, 10'd750, 2'b10, 2'd2);    // Limits are still center
        serveFrame(10'd751, 10'd512, 2'b01, 2'd3);    // Right
        serveFrame(10'd512, 10'd512, 2'b00, 2'd0);
        serveFrame(10'd299, 10'd512, 2'b00, 2'd1);    // Left
        serveFrame(10'd512, 10'd512, 2'b00, 2'd2);
        serveFrame(10'd512, 10'd751, 2'b00, 2'd3);    // Down
        serveFrame(10'd512, 10'd512, 2'b00, 2'd0);
        serveFrame(10'd512, 10'd299, 2'b00, 2'd1);    // Up
        serveFrame(10'd1023, 10'd0, 2'b00, 2'd2);     // Right and up
        serveFrame(10'd0, 10'd1023, 2'b00, 2'd3);     // Straight across
        serveFrame(10'd512, 10'd512, 2'b00, 2'd0);
        repeat (5) begin
            r = $random(seed);
            serveFrame(r[9:0], r[19:10], r[21:20], r[23:22]);
        end
        serveFrame(10'd512, 10'd512, 2'b00, 2'd0);    // Back to rest
        repeat (HOLD_CYCLES + REPEAT_CYCLES) @(posedge CLK);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== verification/joystickSlaveModel.sv ====
`timescale 1ns/1ps

module joystickSlaveModel import joystickPkg::*; (
    input  logic                 sclk,
    input  logic                 ss,        // Active low
    input  logic                 mosi,
    input  jstkFrame             frame,     // Next frame to serve
    output logic                 miso,
    output logic [BYTE_BITS-1:0] cmdByte    // First byte of the last frame
);

    localparam int FRAME_BITS = FRAME_BYTES * BYTE_BITS;

    logic [FRAME_BITS-1:0] served = '0;     // Frame taken as ss drops
    logic [BYTE_BITS-1:0]  inSR   = '0;
    int                    outBit = 0;      // Bits already shifted out
    int                    inBits = 0;      // Command bits captured

    initial cmdByte = '0;

    // MSB is on miso before the first rising sclk
    assign miso = (!ss && outBit < FRAME_BITS) ? served[FRAME_BITS - 1 - outBit] : 1'b0;

    always @(negedge ss) begin
        served = frame;
    end

    // ==================================================================
    // Output side, next bit after every falling sclk
    // ==================================================================
    always @(posedge ss or negedge sclk) begin
        if (ss === 1'b1) begin
            outBit = 0;                     // Frame over
        end else if (ss === 1'b0) begin
            outBit = outBit + 1;
        end
    end

    // ==================================================================
    // Input side, command byte sampled on rising sclk
    // ==================================================================
    always @(posedge ss or posedge sclk) begin
        if (ss === 1'b1) begin
            inBits = 0;
        end else if (ss === 1'b0 && inBits < BYTE_BITS) begin
            inSR   = {inSR[BYTE_BITS-2:0], mosi};   // MSB first
            inBits = inBits + 1;
            if (inBits == BYTE_BITS) begin
                cmdByte = inSR;             // Filler bytes ignored
            end
        end
    end

endmodule

// ==== source/joystickNav.sv ====
`timescale 1ns/1ps

module joystickNav import joystickPkg::*; #(
    parameter int POLL_CYCLES   = 20_000_000,  // 5 Hz at 100 MHz
    parameter int SCLK_HALF     = 750,         // About 66.7 kHz sclk
    parameter int HOLD_CYCLES   = 30_000_000,
    parameter int REPEAT_CYCLES = 10_000_000
) (
    input  logic       CLK,
    input  logic       RST,
    input  logic       miso,
    input  logic [1:0] leds,
    output logic       ss,
    output logic       sclk,
    output logic       mosi,
    output logic       left,
    output logic       right,
    output logic       up,
    output logic       down,
    output logic       click,
    output logic       downClick
);

    posType xPos;   // Latest x from the reader
    posType yPos;

    spiByteIf byteBus ();

    // ==================================================================
    // Serial side
    // ==================================================================
    frameReader #(
        .POLL_CYCLES (POLL_CYCLES)
    ) reader (
        .CLK       (CLK),
        .RST       (RST),
        .leds      (leds),
        .bus       (byteBus.sequencer),
        .ss        (ss),
        .xPos      (xPos),
        .yPos      (yPos),
        .click     (click),
        .downClick (downClick)
    );

    spiByteEngine #(
        .SCLK_HALF (SCLK_HALF)
    ) engine (
        .CLK  (CLK),
        .RST  (RST),
        .miso (miso),
        .bus  (byteBus.engine),
        .sclk (sclk),
        .mosi (mosi)
    );

    // ==================================================================
    // Navigation, low side maps to left and up
    // ==================================================================
    axisRepeater #(
        .HOLD_CYCLES   (HOLD_CYCLES),
        .REPEAT_CYCLES (REPEAT_CYCLES)
    ) xAxis (
        .CLK      (CLK),
        .RST      (RST),
        .pos      (xPos),
        .negPulse (left),
        .posPulse (right)
    );

    axisRepeater #(
        .HOLD_CYCLES   (HOLD_CYCLES),
        .REPEAT_CYCLES (REPEAT_CYCLES)
    ) yAxis (
        .CLK      (CLK),
        .RST      (RST),
        .pos      (yPos),
        .negPulse (up),
        .posPulse (down)
    );

endmodule

// ==== source/axisRepeater.sv ====
`timescale 1ns/1ps

module axisRepeater import joystickPkg::*; #(
    parameter int HOLD_CYCLES   = 30_000_000, // Wait before repeating
    parameter int REPEAT_CYCLES = 10_000_000  // Spacing of repeats
) (
    input  logic   CLK,
    input  logic   RST,
    input  posType pos,
    output logic   negPulse,   // Left or up
    output logic   posPulse    // Right or down
);

    localparam int CNT_MAX = (HOLD_CYCLES > REPEAT_CYCLES) ? HOLD_CYCLES : REPEAT_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    axisState         state;
    axisState         nextState;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] nextCnt;
    logic             nextNeg;
    logic             nextPos;
    logic             isHigh;      // Beyond high limit
    logic             isLow;       // Beyond low limit

    assign isHigh = (pos > HIGH_THRESHOLD);
    assign isLow  = (pos < LOW_THRESHOLD);

    // ==================================================================
    // State, counter and pulse registers
    // ==================================================================
    always_ff @(posedge CLK) begin
        if (RST) begin
            state    <= idle;
            cnt      <= '0;
            negPulse <= 1'b0;
            posPulse <= 1'b0;
        end else begin
            state    <= nextState;
            cnt      <= nextCnt;
            negPulse <= nextNeg;
            posPulse <= nextPos;
        end
    end

    // ==================================================================
    // Next state
    // ==================================================================
    always_comb begin
        nextState = state;
        nextCnt   = '0;
        nextNeg   = 1'b0;
        nextPos   = 1'b0;
        case (state)
            idle: begin
                if (isHigh) begin
                    nextState = posWait;
                    nextPos   = 1'b1;          // Immediate pulse
                end else if (isLow) begin
                    nextState = negWait;
                    nextNeg   = 1'b1;
                end
            end
            posWait: begin
                nextCnt = cnt + 1'b1;
                if (!isHigh) begin
                    nextState = idle;          // Released, no pulse
                end else if (cnt == CNT_W'(HOLD_CYCLES)) begin
                    nextState = posRepeat;
                    nextCnt   = '0;
                end
            end
            posRepeat: begin
                nextCnt = cnt + 1'b1;
                if (!isHigh) begin
                    nextState = idle;
                end else if (cnt == CNT_W'(REPEAT_CYCLES)) begin
                    nextPos = 1'b1;
                    nextCnt = '0;              // Restart repeat interval
                end
            end
            negWait: begin
                nextCnt = cnt + 1'b1;
                if (!isLow) begin
                    nextState = idle;
                end else if (cnt == CNT_W'(HOLD_CYCLES)) begin
                    nextState = negRepeat;
                    nextCnt   = '0;
                end
            end
            negRepeat: begin
                nextCnt = cnt + 1'b1;
                if (!isLow) begin
                    nextState = idle;
                end else if (cnt == CNT_W'(REPEAT_CYCLES)) begin
                    nextNeg = 1'b1;
                    nextCnt = '0;
                end
            end
            default: nextState = idle;
        endcase
    end

endmodule

// ==== source/frameReader.sv ====
`timescale 1ns/1ps

module frameReader import joystickPkg::*; #(
    parameter int POLL_CYCLES = 20_000_000   // CLK cycles between polls
) (
    input  logic        CLK,
    input  logic        RST,
    input  logic [1:0]  leds,          // Low bits of the command byte
    spiByteIf.sequencer bus,
    output logic        ss,            // Active low
    output posType      xPos,
    output posType      yPos,
    output logic        click,
    output logic        downClick
);

    localparam int POLL_W = $clog2(POLL_CYCLES);
    localparam int BYTE_W = $clog2(FRAME_BYTES);

    // ==================================================================
    // Poll and sequencing state
    // ==================================================================
    logic [POLL_W-1:0]    pollCnt;
    logic                 pollDue;     // Poll waiting for a free reader
    logic                 active;      // Frame in progress
    logic                 launch;      // First start next cycle
    logic [BYTE_W-1:0]    byteCnt;     // Bytes already requested and answered
    logic [BYTE_BITS-1:0] cmdByte;
    jstkFrame             workFrame;   // Bytes shift in here
    jstkFrame             nextWork;
    jstkFrame             frameLatch;  // Last complete frame

    // Command byte, top bit marks LED write
    assign cmdByte = {1'b1, {(BYTE_BITS - 3){1'b0}}, leds};

    // Newest byte enters at the bottom, byte 0 ends up on top
    assign nextWork.bytes = {workFrame.bytes[1:FRAME_BYTES-1], bus.rxByte};

    always_ff @(posedge CLK) begin
        if (RST) begin
            pollCnt    <= '0;
            pollDue    <= 1'b0;
            active     <= 1'b0;
            launch     <= 1'b0;
            byteCnt    <= '0;
            ss         <= 1'b1;
            bus.start  <= 1'b0;
            bus.txByte <= '0;
            frameLatch <= '0;
        end else begin
            bus.start <= 1'b0;

            // Begin a frame, ss leads the first start by one cycle
            if (pollDue && !active) begin
                pollDue <= 1'b0;
                active  <= 1'b1;
                launch  <= 1'b1;
                byteCnt <= '0;
                ss      <= 1'b0;
            end

            if (launch) begin
                launch     <= 1'b0;
                bus.start  <= 1'b1;
                bus.txByte <= cmdByte;   // Command goes first
            end

            if (bus.done) begin
                if (byteCnt == BYTE_W'(FRAME_BYTES - 1)) begin
                    active     <= 1'b0;
                    ss         <= 1'b1;
                    frameLatch <= nextWork;    // Same cycle as ss release
                end else begin
                    byteCnt    <= byteCnt + 1'b1;
                    bus.start  <= 1'b1;        // Back to back
                    bus.txByte <= '0;          // Filler bytes
                end
            end

            // Poll timer last so a fresh tick is never lost
            if (pollCnt == POLL_W'(POLL_CYCLES - 1)) begin
                pollCnt <= '0;
                pollDue <= 1'b1;
            end else begin
                pollCnt <= pollCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (bus.done) begin
            workFrame <= nextWork;
        end
    end

    // ==================================================================
    // Field decode of the latched frame
    // ==================================================================
    assign xPos      = {frameLatch.fields.xHigh, frameLatch.fields.xLow};
    assign yPos      = {frameLatch.fields.yHigh, frameLatch.fields.yLow};
    assign click     = frameLatch.fields.click;
    assign downClick = frameLatch.fields.downClick;

endmodule

// ==== source/spiByteEngine.sv ====
`timescale 1ns/1ps

module spiByteEngine import joystickPkg::*; #(
    parameter int SCLK_HALF = 750       // CLK cycles per sclk half period
) (
    input  logic          CLK,
    input  logic          RST,
    input  logic          miso,
    spiByteIf.engine      bus,
    output logic          sclk,         // Idles low
    output logic          mosi
);

    localparam int HALF_W = $clog2(SCLK_HALF + 1);
    localparam int BIT_W  = $clog2(BYTE_BITS);

    // ==================================================================
    // Transfer state
    // ==================================================================
    logic                 busy;         // Byte in flight
    logic                 finish;       // Last falling edge seen
    logic [HALF_W-1:0]    halfCnt;      // Position inside half period
    logic [BIT_W-1:0]     bitCnt;       // Falling edges so far
    logic [BYTE_BITS-1:0] wSR;          // Write shift register
    logic [BYTE_BITS-1:0] rSR;          // Read shift register
    logic                 halfEnd;

    // Half period over while bits still moving
    assign halfEnd = busy && !finish && (halfCnt == HALF_W'(SCLK_HALF - 1));

    assign mosi       = wSR[BYTE_BITS-1]; // MSB first
    assign bus.rxByte = rSR;

    // ==================================================================
    // Clock generation and write path
    // ==================================================================
    always_ff @(posedge CLK) begin
        if (RST) begin
            busy     <= 1'b0;
            finish   <= 1'b0;
            halfCnt  <= '0;
            bitCnt   <= '0;
            sclk     <= 1'b0;
            wSR      <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (!busy) begin
                if (bus.start) begin
                    busy    <= 1'b1;
                    halfCnt <= '0;
                    bitCnt  <= '0;
                    wSR     <= bus.txByte; // First bit on mosi right away
                end
            end else if (finish) begin
                // One spare cycle, then hand the byte back
                finish   <= 1'b0;
                busy     <= 1'b0;
                bus.done <= 1'b1;
            end else if (halfEnd) begin
                halfCnt <= '0;
                sclk    <= ~sclk;
                if (sclk) begin
                    // Falling edge, next bit out
                    wSR    <= {wSR[BYTE_BITS-2:0], 1'b0};
                    bitCnt <= bitCnt + 1'b1;
                    if (bitCnt == BIT_W'(BYTE_BITS - 1)) begin
                        finish <= 1'b1;   // Eighth period complete
                    end
                end
            end else begin
                halfCnt <= halfCnt + 1'b1;
            end
        end
    end

    // ==================================================================
    // Read path
    // ==================================================================

    // Sample miso where sclk rises, slave moves it on the fall
    always_ff @(posedge CLK) begin
        if (halfEnd && !sclk) begin
            rSR <= {rSR[BYTE_BITS-2:0], miso};
        end
    end

endmodule

// ==== source/spiByteIf.sv ====
`timescale 1ns/1ps

// One byte exchange between frame sequencer and SPI engine
interface spiByteIf import joystickPkg::*; ();

    logic                 start;  // One cycle, txByte valid
    logic [BYTE_BITS-1:0] txByte; // Byte to shift out
    logic [BYTE_BITS-1:0] rxByte; // Byte shifted in, valid with done
    logic                 done;   // One cycle at end of transfer

    // Frame side
    modport sequencer (
        output start,
        output txByte,
        input  rxByte,
        input  done
    );

    // Serial side
    modport engine (
        input  start,
        input  txByte,
        output rxByte,
        output done
    );

endinterface

// ==== source/joystickPkg.sv ====
package joystickPkg;

    // ==================================================================
    // Serial frame geometry
    // ==================================================================
    localparam int BYTE_BITS   = 8;   // Bits per SPI byte
    localparam int FRAME_BYTES = 5;   // Bytes per joystick poll
    localparam int POS_BITS    = 10;  // Axis resolution

    typedef logic [POS_BITS-1:0] posType;

    // Deflection limits, strict on entry
    localparam posType HIGH_THRESHOLD = 10'd750;
    localparam posType LOW_THRESHOLD  = 10'd300;

    // ==================================================================
    // Frame layout as received from the joystick module
    // ==================================================================
    typedef struct packed {
        logic [7:0] xLow;      // Byte 0
        logic [5:0] xHighPad;
        logic [1:0] xHigh;     // Byte 1, top bits of x
        logic [7:0] yLow;      // Byte 2
        logic [5:0] yHighPad;
        logic [1:0] yHigh;     // Byte 3, top bits of y
        logic [5:0] buttonPad;
        logic       downClick; // Byte 4 buttons
        logic       click;
    } jstkFields;

    // Same 40 bits, seen as raw bytes or as decoded fields
    typedef union packed {
        logic [0:FRAME_BYTES-1][BYTE_BITS-1:0] bytes; // Index 0 is first received
        jstkFields                             fields;
    } jstkFrame;

    // ==================================================================
    // Axis repeat controller states
    // ==================================================================
    typedef enum logic [2:0] {
        idle,       // Stick near center
        negWait,    // Below low limit, hold time running
        negRepeat,  // Below low limit, repeating
        posWait,    // Above high limit, hold time running
        posRepeat   // Above high limit, repeating
    } axisState;

endpackage
